//--- Makefile
TOOL     := verilator
TOP      := tb_seq_core
RTL_TOP  := seq_core
FLIST    := seq_core.f
FLAGS    := --binary --timing --assert -j 0
PASS_MSG := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# the run passes only when the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

//--- hdl/seq_control.sv
module seq_control #(
    parameter int index_width = seq_pkg::index_width
) (
    input  logic                            clk,
    input  logic                            reset,
    // host control
    input  logic                            ctrl_set,
    input  seq_pkg::ctrl_cmd_t              ctrl_cmd,
    input  logic [index_width-1:0]          end_cnt_in,
    input  logic                            end_cnt_set,
    // progress inputs
    input  logic                            nslave_reset,    // slave reset, low active
    input  logic                            slot_done,
    input  logic                            dma_init_done,
    // outputs
    output seq_pkg::seq_state_t             state,
    output logic [index_width-1:0]          main_cnt,
    output logic [index_width-1:0]          end_cnt,
    output logic [(1 << index_width)-1:0]   slot_trigger,    // one-hot current slot
    output logic                            host_owns,
    output seq_pkg::slot_seq_cmd_t          seq_cmd,
    output logic [3:0]                      status
);

    localparam int slot_cnt = 1 << index_width;

    assign host_owns = (state == seq_pkg::idle);
    assign status    = state;    // status word is the raw state

    ////////////////////
    // table commands
    ////////////////////
    always_comb begin
        seq_cmd.profile_inc = (state == seq_pkg::reprog) ||
                              (state == seq_pkg::wait_reset_low) ||
                              (state == seq_pkg::wait_reset_high);
        seq_cmd.intr_clear  = (state == seq_pkg::clear_engines);
        seq_cmd.intr_merge  = (state == seq_pkg::wait_finish);
    end

    ////////////////////
    // end count, host loads while idle
    ////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            end_cnt <= '0;
        end else if (host_owns && end_cnt_set) begin
            end_cnt <= end_cnt_in;
        end
    end

    ////////////////////
    // sequencer FSM
    ////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= seq_pkg::idle;
            main_cnt     <= '0;
            slot_trigger <= '0;
        end else if (ctrl_set && ctrl_cmd == seq_pkg::clear) begin
            state        <= seq_pkg::idle;
            main_cnt     <= '0;
            slot_trigger <= '0;
        end else if (ctrl_set && ctrl_cmd == seq_pkg::shutdown) begin
            state <= seq_pkg::idle;    // counter kept for inspection
        end else if (ctrl_set && ctrl_cmd == seq_pkg::start && host_owns) begin
            state        <= seq_pkg::reprog;
            main_cnt     <= '0;
            slot_trigger <= slot_cnt'(1);    // slot 0
        end else begin
            case (state)
                seq_pkg::reprog: begin
                    state <= seq_pkg::wait_reset_low;    // request is one cycle
                end
                seq_pkg::wait_reset_low: begin
                    if (!nslave_reset) state <= seq_pkg::wait_reset_high;
                end
                seq_pkg::wait_reset_high: begin
                    if (nslave_reset) state <= seq_pkg::clear_engines;
                end
                seq_pkg::clear_engines: begin
                    state <= seq_pkg::init_engines;
                end
                seq_pkg::init_engines: begin
                    state <= seq_pkg::init_dma;
                end
                seq_pkg::init_dma: begin
                    if (dma_init_done) state <= seq_pkg::triggering;  // top task acked
                end
                seq_pkg::triggering: begin
                    state <= seq_pkg::wait_finish;
                end
                seq_pkg::wait_finish: begin
                    if (slot_done) begin
                        if (main_cnt < end_cnt) begin
                            main_cnt     <= main_cnt + index_width'(1);
                            slot_trigger <= slot_trigger << 1;    // next slot
                            state        <= seq_pkg::reprog;
                        end else begin
                            main_cnt     <= '0;    // run complete
                            slot_trigger <= '0;
                            state        <= seq_pkg::idle;
                        end
                    end
                end
                default: begin
                    state <= state;    // idle waits for start
                end
            endcase
        end
    end

endmodule

//--- hdl/seq_core.sv
module seq_core #(
    parameter int index_width   = seq_pkg::index_width,
    parameter int addr_width    = seq_pkg::addr_width,
    parameter int size_width    = seq_pkg::size_width,
    parameter int profile_width = seq_pkg::profile_width,
    parameter int mask_width    = seq_pkg::mask_width,
    parameter int dma_task_cnt  = seq_pkg::dma_task_cnt
) (
    input  logic                            clk,
    input  logic                            reset,
    ////////////////////
    // host side
    ////////////////////
    input  logic [index_width-1:0]          wr_index,
    input  seq_pkg::slot_entry_t            wr_data,
    input  seq_pkg::slot_field_sel_t        wr_set,
    output seq_pkg::slot_field_sel_t        wr_accept,
    input  logic [index_width-1:0]          rd_index,
    input  logic                            rd_req,
    output logic                            rd_ready,
    output seq_pkg::slot_entry_t            entry,        // shared with the slave
    input  logic [index_width-1:0]          end_cnt_in,
    input  logic                            end_cnt_set,
    input  logic                            ctrl_set,
    input  seq_pkg::ctrl_cmd_t              ctrl_cmd,
    output logic [index_width-1:0]          main_cnt,
    output logic [index_width-1:0]          end_cnt,
    output logic [3:0]                      status,
    ////////////////////
    // slave side
    ////////////////////
    output logic [(1 << index_width)-1:0]   slave_reprog,
    input  logic                            nslave_reset,
    output logic [mask_width-1:0]           mgs_load_reset,
    output logic [mask_width-1:0]           mgs_store_reset,
    output logic [mask_width-1:0]           mgs_load_init,
    output logic [mask_width-1:0]           mgs_store_init,
    output logic [dma_task_cnt-1:0]         slave_init,
    input  logic [dma_task_cnt-1:0]         slave_fin_init,
    input  logic [mask_width-1:0]           mgs_fin_exec
);

    seq_pkg::seq_state_t            state;
    seq_pkg::slot_seq_cmd_t         seq_cmd;
    logic                           host_owns;
    logic                           slot_done;
    logic                           dma_init_done;
    logic [(1 << index_width)-1:0]  slot_trigger;

    slot_table #(
        .index_width   (index_width),
        .addr_width    (addr_width),
        .size_width    (size_width),
        .profile_width (profile_width),
        .mask_width    (mask_width)
    ) u_slot_table (
        .clk          (clk),
        .reset        (reset),
        .host_owns    (host_owns),
        .seq_cmd      (seq_cmd),
        .main_cnt     (main_cnt),
        .wr_index     (wr_index),
        .wr_data      (wr_data),
        .wr_set       (wr_set),
        .wr_accept    (wr_accept),
        .rd_index     (rd_index),
        .rd_req       (rd_req),
        .rd_ready     (rd_ready),
        .mgs_fin_exec (mgs_fin_exec),
        .entry        (entry),
        .slot_done    (slot_done)
    );

    seq_control #(
        .index_width (index_width)
    ) u_seq_control (
        .clk           (clk),
        .reset         (reset),
        .ctrl_set      (ctrl_set),
        .ctrl_cmd      (ctrl_cmd),
        .end_cnt_in    (end_cnt_in),
        .end_cnt_set   (end_cnt_set),
        .nslave_reset  (nslave_reset),
        .slot_done     (slot_done),
        .dma_init_done (dma_init_done),
        .state         (state),
        .main_cnt      (main_cnt),
        .end_cnt       (end_cnt),
        .slot_trigger  (slot_trigger),
        .host_owns     (host_owns),
        .seq_cmd       (seq_cmd),
        .status        (status)
    );

    // masks come from the slot under main_cnt while running
    slave_drive #(
        .mask_width   (mask_width),
        .dma_task_cnt (dma_task_cnt),
        .index_width  (index_width)
    ) u_slave_drive (
        .clk             (clk),
        .reset           (reset),
        .state           (state),
        .slot_trigger    (slot_trigger),
        .ld_mask         (entry.ld_mask),
        .st_mask         (entry.st_mask),
        .slave_fin_init  (slave_fin_init),
        .slave_reprog    (slave_reprog),
        .mgs_load_reset  (mgs_load_reset),
        .mgs_store_reset (mgs_store_reset),
        .mgs_load_init   (mgs_load_init),
        .mgs_store_init  (mgs_store_init),
        .slave_init      (slave_init),
        .dma_init_done   (dma_init_done)
    );

endmodule

//--- hdl/seq_pkg.sv
package seq_pkg;

    ////////////////////
    // default sizes, the top level passes its own copies down
    ////////////////////
    parameter int index_width   = 3;    // slot index and counter, 8 slots
    parameter int addr_width    = 32;
    parameter int size_width    = 26;
    parameter int profile_width = 32;
    parameter int mask_width    = 8;    // stream engine masks
    parameter int dma_task_cnt  = 8;    // dma init steps per slot

    ////////////////////
    // encodings
    ////////////////////
    typedef enum logic [3:0] {
        idle            = 4'd0,    // host owns the table
        reprog          = 4'd1,    // one cycle, slave_reprog pulse
        wait_reset_low  = 4'd2,
        wait_reset_high = 4'd3,
        clear_engines   = 4'd4,    // engine reset strobes
        init_engines    = 4'd5,    // engine init strobes
        init_dma        = 4'd6,    // one-hot task chain
        triggering      = 4'd7,
        wait_finish     = 4'd8     // collect mgs_fin_exec
    } seq_state_t;

    typedef enum logic [3:0] {
        clear    = 4'd0,    // back to idle, counter zeroed
        shutdown = 4'd1,    // back to idle, counter kept
        start    = 4'd2     // only taken from idle
    } ctrl_cmd_t;

    ////////////////////
    // slot entry and its access structs
    ////////////////////
    typedef struct packed {
        logic [addr_width-1:0]    src_addr;
        logic [size_width-1:0]    src_size;
        logic [addr_width-1:0]    dst_addr;
        logic [size_width-1:0]    dst_size;
        logic [profile_width-1:0] profile;    // reprogram cycle count
        logic [mask_width-1:0]    ld_mask;
        logic [mask_width-1:0]    st_mask;
        logic [mask_width-1:0]    intr_mask;  // finished store engines
    } slot_entry_t;

    // one bit per entry field, host strobes and accepts
    typedef struct packed {
        logic src_addr;
        logic src_size;
        logic dst_addr;
        logic dst_size;
        logic profile;
        logic ld_mask;
        logic st_mask;
        logic intr_mask;
    } slot_field_sel_t;

    // sequencer updates on the current slot
    typedef struct packed {
        logic profile_inc;
        logic intr_merge;
        logic intr_clear;
    } slot_seq_cmd_t;

endpackage

//--- hdl/slave_drive.sv
module slave_drive #(
    parameter int mask_width   = seq_pkg::mask_width,
    parameter int dma_task_cnt = seq_pkg::dma_task_cnt,
    parameter int index_width  = seq_pkg::index_width
) (
    input  logic                            clk,
    input  logic                            reset,
    input  seq_pkg::seq_state_t             state,
    input  logic [(1 << index_width)-1:0]   slot_trigger,
    input  logic [mask_width-1:0]           ld_mask,    // current slot
    input  logic [mask_width-1:0]           st_mask,
    input  logic [dma_task_cnt-1:0]         slave_fin_init,
    output logic [(1 << index_width)-1:0]   slave_reprog,
    output logic [mask_width-1:0]           mgs_load_reset,
    output logic [mask_width-1:0]           mgs_store_reset,
    output logic [mask_width-1:0]           mgs_load_init,
    output logic [mask_width-1:0]           mgs_store_init,
    output logic [dma_task_cnt-1:0]         slave_init,
    output logic                            dma_init_done
);

    logic [dma_task_cnt-1:0] dma_task;    // one-hot pending task
    logic                    in_dma;

    assign in_dma = (state == seq_pkg::init_dma);

    ////////////////////
    // dma init chain
    ////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dma_task <= '0;
        end else if (state == seq_pkg::init_engines) begin
            dma_task <= dma_task_cnt'(1);    // first task on entry to init_dma
        end else if (!in_dma || dma_init_done) begin
            dma_task <= '0;                  // done, or run stopped
        end else if (|slave_fin_init) begin
            dma_task <= dma_task << 1;       // one step per ack
        end
    end

    assign dma_init_done = in_dma && slave_fin_init[dma_task_cnt-1];
    assign slave_init    = in_dma ? dma_task : '0;

    ////////////////////
    // state decoded strobes
    ////////////////////
    assign slave_reprog    = (state == seq_pkg::reprog) ? slot_trigger : '0;
    assign mgs_load_reset  = (state == seq_pkg::clear_engines) ? ld_mask : '0;
    assign mgs_store_reset = (state == seq_pkg::clear_engines) ? st_mask : '0;
    assign mgs_load_init   = (state == seq_pkg::init_engines)  ? ld_mask : '0;
    assign mgs_store_init  = (state == seq_pkg::init_engines)  ? st_mask : '0;

endmodule

//--- hdl/slot_table.sv
module slot_table #(
    parameter int index_width   = seq_pkg::index_width,
    parameter int addr_width    = seq_pkg::addr_width,
    parameter int size_width    = seq_pkg::size_width,
    parameter int profile_width = seq_pkg::profile_width,
    parameter int mask_width    = seq_pkg::mask_width
) (
    input  logic                        clk,
    input  logic                        reset,
    // sequencer side
    input  logic                        host_owns,    // core is idle
    input  seq_pkg::slot_seq_cmd_t      seq_cmd,
    input  logic [index_width-1:0]      main_cnt,
    // host writes
    input  logic [index_width-1:0]      wr_index,
    input  seq_pkg::slot_entry_t        wr_data,
    input  seq_pkg::slot_field_sel_t    wr_set,
    output seq_pkg::slot_field_sel_t    wr_accept,
    // host reads
    input  logic [index_width-1:0]      rd_index,
    input  logic                        rd_req,
    output logic                        rd_ready,
    // engine completion
    input  logic [mask_width-1:0]       mgs_fin_exec,
    output seq_pkg::slot_entry_t        entry,
    output logic                        slot_done
);

    localparam int slot_cnt = 1 << index_width;

    ////////////////////
    // storage, one array per field
    ////////////////////
    logic [addr_width-1:0]    src_addr_mem [slot_cnt];
    logic [size_width-1:0]    src_size_mem [slot_cnt];
    logic [addr_width-1:0]    dst_addr_mem [slot_cnt];
    logic [size_width-1:0]    dst_size_mem [slot_cnt];
    logic [profile_width-1:0] profile_mem  [slot_cnt];
    logic [mask_width-1:0]    ld_mask_mem  [slot_cnt];
    logic [mask_width-1:0]    st_mask_mem  [slot_cnt];
    logic [mask_width-1:0]    intr_mem     [slot_cnt];

    logic [index_width-1:0] wr_idx;    // host slot in idle, else current slot
    logic [index_width-1:0] rd_idx;

    assign wr_idx = host_owns ? wr_index : main_cnt;
    assign rd_idx = host_owns ? rd_index : main_cnt;

    // host access only while idle
    assign wr_accept = host_owns ? wr_set : '0;
    assign rd_ready  = rd_req & host_owns;

    ////////////////////
    // updates
    ////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < slot_cnt; i++) begin
                src_addr_mem[i] <= '0;
                src_size_mem[i] <= '0;
                dst_addr_mem[i] <= '0;
                dst_size_mem[i] <= '0;
                profile_mem[i]  <= '0;
                ld_mask_mem[i]  <= '0;
                st_mask_mem[i]  <= '0;
                intr_mem[i]     <= '0;
            end
        end else begin
            if (wr_accept.src_addr) src_addr_mem[wr_idx] <= wr_data.src_addr;
            if (wr_accept.src_size) src_size_mem[wr_idx] <= wr_data.src_size;
            if (wr_accept.dst_addr) dst_addr_mem[wr_idx] <= wr_data.dst_addr;
            if (wr_accept.dst_size) dst_size_mem[wr_idx] <= wr_data.dst_size;
            if (wr_accept.ld_mask)  ld_mask_mem[wr_idx]  <= wr_data.ld_mask;
            if (wr_accept.st_mask)  st_mask_mem[wr_idx]  <= wr_data.st_mask;

            // profile shared by host load and reprogram counting
            if (wr_accept.profile) begin
                profile_mem[wr_idx] <= wr_data.profile;
            end else if (seq_cmd.profile_inc) begin
                profile_mem[wr_idx] <= profile_mem[wr_idx] + profile_width'(1);
            end

            // interrupt mask: host load, clear before init, or merge of done bits
            if (wr_accept.intr_mask) begin
                intr_mem[wr_idx] <= wr_data.intr_mask;
            end else if (seq_cmd.intr_clear) begin
                intr_mem[wr_idx] <= '0;
            end else if (seq_cmd.intr_merge) begin
                intr_mem[wr_idx] <= intr_mem[wr_idx] | mgs_fin_exec;  // sticky bits
            end
        end
    end

    ////////////////////
    // shared read port
    ////////////////////
    always_comb begin
        entry.src_addr  = src_addr_mem[rd_idx];
        entry.src_size  = src_size_mem[rd_idx];
        entry.dst_addr  = dst_addr_mem[rd_idx];
        entry.dst_size  = dst_size_mem[rd_idx];
        entry.profile   = profile_mem[rd_idx];
        entry.ld_mask   = ld_mask_mem[rd_idx];
        entry.st_mask   = st_mask_mem[rd_idx];
        entry.intr_mask = intr_mem[rd_idx];
    end

    // every store engine of the slot has reported
    assign slot_done = (entry.intr_mask == entry.st_mask);

endmodule

//--- seq_core.f
+incdir+test
hdl/seq_pkg.sv
hdl/slot_table.sv
hdl/seq_control.sv
hdl/slave_drive.sv
hdl/seq_core.sv
test/tb_seq_core.sv

//--- test/seq_vectors.svh
// one row per slot with the fields to load and the slave reset timing
// columns are src_addr src_size dst_addr dst_size profile ld_mask st_mask hi lo
// hi counts reset-high cycles after the reprog pulse, lo the reset-low cycles after them
typedef struct packed {
    logic [seq_pkg::addr_width-1:0]    src_addr;
    logic [seq_pkg::size_width-1:0]    src_size;
    logic [seq_pkg::addr_width-1:0]    dst_addr;
    logic [seq_pkg::size_width-1:0]    dst_size;
    logic [seq_pkg::profile_width-1:0] profile;    // start value of the cycle count
    logic [seq_pkg::mask_width-1:0]    ld_mask;    // never zero here
    logic [seq_pkg::mask_width-1:0]    st_mask;
    int                                hi_cycles;
    int                                lo_cycles;  // at least 1
} vec_row_t;

localparam int vec_end_cnt = 5;    // slots 6 and 7 are loaded but not run

localparam vec_row_t vec_table [slots] = '{
    '{32'h1000_0000, 26'h400,     32'h2000_0000, 26'h400, 32'h0,         8'h01, 8'h01, 2, 3},
    '{32'h1000_1000, 26'h80,      32'h2000_1000, 26'h100, 32'h10,        8'h03, 8'h02, 0, 1},
    '{32'h1000_2000, 26'h3ff_ffff, 32'h2000_2000, 26'h40, 32'h100,       8'h0f, 8'h05, 4, 2},
    '{32'h1000_3000, 26'h10,      32'h2000_3000, 26'h10,  32'hffff_0000, 8'h80, 8'hf0, 1, 5},
    '{32'h1000_4000, 26'h200,     32'h2000_4000, 26'h200, 32'h0,         8'h22, 8'h00, 3, 1},
    '{32'h1000_5000, 26'h1,       32'h2000_5000, 26'h2,   32'h7,         8'hff, 8'hff, 0, 4},
    '{32'h1000_6000, 26'h20,      32'h2000_6000, 26'h20,  32'h55,        8'h11, 8'h11, 1, 1},
    '{32'h1000_7000, 26'h30,      32'h2000_7000, 26'h30,  32'haa,        8'h44, 8'h44, 2, 2}
};

//--- test/tb_seq_core.sv
module tb_seq_core;

    localparam int slots     = 1 << seq_pkg::index_width;
    localparam int run_limit = 2000;    // cycles allowed for one run

    `include "seq_vectors.svh"

    logic                                  clk;
    logic                                  reset;
    logic [seq_pkg::index_width-1:0]       wr_index, rd_index, end_cnt_in, main_cnt, end_cnt;
    seq_pkg::slot_entry_t                  wr_data, entry;
    seq_pkg::slot_field_sel_t              wr_set, wr_accept;
    logic                                  rd_req, rd_ready, end_cnt_set, ctrl_set;
    seq_pkg::ctrl_cmd_t                    ctrl_cmd;
    logic [3:0]                            status;
    logic [slots-1:0]                      slave_reprog;
    logic                                  nslave_reset;
    logic [seq_pkg::mask_width-1:0]        mgs_load_reset, mgs_store_reset;
    logic [seq_pkg::mask_width-1:0]        mgs_load_init, mgs_store_init, mgs_fin_exec;
    logic [seq_pkg::dma_task_cnt-1:0]      slave_init, slave_fin_init;

    ////////////////////
    // slave model and monitor state
    ////////////////////
    int exp_slot;      // next slot due on slave_reprog
    int cur_slot;
    int hi_left;       // reset phases still ahead
    int lo_left;
    int dma_idx;       // next dma task expected
    int ack_delay;
    int clr_seen;      // strobe cycles of the current slot
    int init_seen;
    logic [seq_pkg::mask_width-1:0] fin_left;    // store engines still running
    int value_errors;
    int timeout_errors;

    seq_core #(
        .index_width   (seq_pkg::index_width),
        .addr_width    (seq_pkg::addr_width),
        .size_width    (seq_pkg::size_width),
        .profile_width (seq_pkg::profile_width),
        .mask_width    (seq_pkg::mask_width),
        .dma_task_cnt  (seq_pkg::dma_task_cnt)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;    // inputs change a little after the edge
    endtask

    // table entry as loaded, or as left by a full run over the slot
    function automatic seq_pkg::slot_entry_t expected_entry(input int i, input bit ran);
        seq_pkg::slot_entry_t e;
        e.src_addr  = vec_table[i].src_addr;
        e.src_size  = vec_table[i].src_size;
        e.dst_addr  = vec_table[i].dst_addr;
        e.dst_size  = vec_table[i].dst_size;
        e.profile   = vec_table[i].profile;
        e.ld_mask   = vec_table[i].ld_mask;
        e.st_mask   = vec_table[i].st_mask;
        e.intr_mask = '0;
        if (ran) begin
            // reprog cycle, hi cycles plus the first low one, then lo cycles low
            e.profile   = e.profile + seq_pkg::profile_width'(2 + vec_table[i].hi_cycles
                                                             + vec_table[i].lo_cycles);
            e.intr_mask = vec_table[i].st_mask;    // every store engine reported
        end
        return e;
    endfunction

    task automatic load_slot(input int i);
        wr_index = seq_pkg::index_width'(i);
        wr_data  = expected_entry(i, 1'b0);
        wr_set   = 8'hF0;    // addresses and sizes
        #1;
        check_value("wr_accept", 256'(wr_accept), 256'(wr_set));
        next_cycle();
        wr_set = 8'h0F;      // profile and masks
        #1;
        check_value("wr_accept", 256'(wr_accept), 256'(wr_set));
        next_cycle();
        wr_set = '0;
    endtask

    task automatic read_slot(input int i, input bit ran);
        rd_index = seq_pkg::index_width'(i);
        rd_req   = 1'b1;
        #1;
        check_value("rd_ready", 256'(rd_ready), 256'(1));
        check_value($sformatf("entry[%0d]", i), 256'(entry), 256'(expected_entry(i, ran)));
        rd_req = 1'b0;
        #1;
        check_value("rd_ready", 256'(rd_ready), 256'(0));    // follows rd_req
    endtask

    task automatic close_slot();
        check_value("clear strobe cycles", 256'(clr_seen), 256'(1));
        check_value("init strobe cycles", 256'(init_seen), 256'(1));
        clr_seen  = 0;
        init_seen = 0;
    endtask

    ////////////////////
    // one slave cycle that observes first and then answers
    ////////////////////
    task automatic model_cycle();
        logic [seq_pkg::mask_width-1:0] ld;
        logic [seq_pkg::mask_width-1:0] st;
        if (slave_reprog != '0) begin
            check_value("slave_reprog", 256'(slave_reprog), 256'(1) << exp_slot);
            if (exp_slot > 0) close_slot();
            cur_slot = exp_slot % slots;
            exp_slot++;
            hi_left      = vec_table[cur_slot].hi_cycles;
            lo_left      = vec_table[cur_slot].lo_cycles;
            nslave_reset = 1'b1;
        end else if (hi_left > 0) begin
            hi_left--;
            nslave_reset = 1'b1;
        end else if (lo_left > 0) begin
            lo_left--;
            nslave_reset = 1'b0;    // slave in reset
        end else begin
            nslave_reset = 1'b1;
        end
        ld = vec_table[cur_slot].ld_mask;
        st = vec_table[cur_slot].st_mask;
        if ((mgs_load_reset | mgs_store_reset) != '0) begin
            clr_seen++;
            check_value("mgs_load_reset", 256'(mgs_load_reset), 256'(ld));
            check_value("mgs_store_reset", 256'(mgs_store_reset), 256'(st));
        end
        if ((mgs_load_init | mgs_store_init) != '0) begin
            init_seen++;
            check_value("mgs_load_init", 256'(mgs_load_init), 256'(ld));
            check_value("mgs_store_init", 256'(mgs_store_init), 256'(st));
        end
        // each dma task acked after a random delay
        slave_fin_init = '0;
        if (slave_init != '0) begin
            check_value("slave_init", 256'(slave_init), 256'(1) << dma_idx);
            if (ack_delay == 0) begin
                slave_fin_init = slave_init;
                dma_idx++;
                ack_delay = $urandom % 4;
            end else begin
                ack_delay--;
            end
        end
        if (status == seq_pkg::triggering) begin
            check_value("dma tasks acked", 256'(dma_idx), 256'(seq_pkg::dma_task_cnt));
            dma_idx  = 0;
            fin_left = st;    // engines that must report
        end
        mgs_fin_exec = '0;
        if (status == seq_pkg::wait_finish && fin_left != '0 && ($urandom % 3) == 0) begin
            mgs_fin_exec = fin_left & (-fin_left);    // lowest open engine
            fin_left     = fin_left & ~mgs_fin_exec;
        end
    endtask

    ////////////////////
    // one run from start that may stop at the reprog of abort_slot
    ////////////////////
    task automatic run_table(input int abort_slot, input seq_pkg::ctrl_cmd_t abort_cmd);
        int cycles;
        int kept_cnt;
        bit stopped;
        exp_slot  = 0;
        cur_slot  = 0;
        hi_left   = 0;
        lo_left   = 0;
        dma_idx   = 0;
        ack_delay = 0;
        clr_seen  = 0;
        init_seen = 0;
        fin_left  = '0;
        cycles    = 0;
        kept_cnt  = 0;
        stopped   = 1'b0;
        ctrl_cmd  = seq_pkg::start;
        ctrl_set  = 1'b1;
        next_cycle();
        ctrl_set = 1'b0;
        while (status != seq_pkg::idle && !stopped && cycles < run_limit) begin
            model_cycle();
            // host write and end count load in the middle of the run
            wr_set      = (cycles == 3) ? 8'hFF : 8'h00;
            wr_data     = '1;
            end_cnt_in  = '0;
            end_cnt_set = (cycles == 3);
            #1;
            check_value("wr_accept", 256'(wr_accept), 256'(0));
            if (abort_slot >= 0 && slave_reprog != '0 && exp_slot - 1 == abort_slot) begin
                kept_cnt = (abort_cmd == seq_pkg::clear) ? 0 : abort_slot;
                ctrl_cmd = abort_cmd;
                ctrl_set = 1'b1;
                stopped  = 1'b1;
            end
            next_cycle();
            cycles++;
        end
        ctrl_set    = 1'b0;
        wr_set      = '0;
        end_cnt_set = 1'b0;
        if (cycles >= run_limit) begin
            timeout_errors++;
            $display("timeout, the run did not return to idle within %0d cycles", run_limit);
        end else if (stopped) begin
            check_value("status", 256'(status), 256'(seq_pkg::idle));
            check_value("main_cnt", 256'(main_cnt), 256'(kept_cnt));
        end else begin
            close_slot();
            check_value("slots run", 256'(exp_slot), 256'(vec_end_cnt + 1));
            check_value("main_cnt", 256'(main_cnt), 256'(0));
            check_value("end_cnt", 256'(end_cnt), 256'(vec_end_cnt));
        end
        nslave_reset   = 1'b1;
        slave_fin_init = '0;
        mgs_fin_exec   = '0;
    endtask

    initial begin
        void'($urandom(32'h8000_a5d5));
        value_errors   = 0;
        timeout_errors = 0;
        reset          = 1'b0;
        wr_index       = '0;
        wr_data        = '0;
        wr_set         = '0;
        rd_index       = '0;
        rd_req         = 1'b0;
        end_cnt_in     = '0;
        end_cnt_set    = 1'b0;
        ctrl_set       = 1'b0;
        ctrl_cmd       = seq_pkg::clear;
        nslave_reset   = 1'b1;
        slave_fin_init = '0;
        mgs_fin_exec   = '0;
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b1;
        check_value("status", 256'(status), 256'(seq_pkg::idle));
        check_value("slave_reprog", 256'(slave_reprog), 256'(0));
        check_value("slave_init", 256'(slave_init), 256'(0));

        ////////////////////
        // load while idle and read back
        ////////////////////
        for (int i = 0; i < slots; i++) load_slot(i);
        end_cnt_in  = seq_pkg::index_width'(vec_end_cnt);
        end_cnt_set = 1'b1;
        next_cycle();
        end_cnt_set = 1'b0;
        for (int i = 0; i < slots; i++) read_slot(i, 1'b0);

        // full run, then profiles counted and masks merged up to the end count
        run_table(-1, seq_pkg::clear);
        for (int i = 0; i < slots; i++) read_slot(i, i <= vec_end_cnt);

        // host stops the core mid-run
        run_table(2, seq_pkg::shutdown);
        run_table(3, seq_pkg::clear);

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
